// ==== src/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

  // Instruction fields, as they come from the IR
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;   // Low bits of the offset on R-type
  typedef logic [15:0] offset_t;

  // Datapath control fields
  typedef logic [2:0] aluOp_t;
  typedef logic [1:0] muxSel2_t;
  typedef logic [2:0] muxSel3_t;

  // Step counter, shared by fetch and execute
  typedef logic [3:0] step_t;

  typedef enum logic [2:0] {
    kindNone,
    kindAdd,
    kindSub,
    kindAddi,
    kindBeq,
    kindBne,
    kindBle,
    kindBgt
  } instrKind_t;

  typedef enum logic [1:0] {
    stReset,
    stFetch,
    stExecute
  } seqState_t;

  typedef struct packed {
    seqState_t  state;
    instrKind_t kind;   // Kind of the instruction being executed
    step_t      step;
  } phase_t;

  typedef struct packed {
    logic eq;
    logic gt;
  } aluFlags_t;

  typedef struct packed {
    logic     pcWrite;
    logic     irWrite;
    logic     regWrite;
    logic     abWrite;
    logic     aluOutWrite;
    aluOp_t   aluOp;
    muxSel2_t aluSrcA;
    muxSel2_t aluSrcB;
    muxSel2_t regDst;
    muxSel3_t memToReg;
    muxSel3_t pcSource;
  } controlWord_t;

  // Kept opcodes and function codes
  localparam opcode_t opRType = 6'b000000;
  localparam opcode_t opBeq   = 6'b000100;
  localparam opcode_t opBne   = 6'b000101;
  localparam opcode_t opBle   = 6'b000110;
  localparam opcode_t opBgt   = 6'b000111;
  localparam opcode_t opAddi  = 6'b001000;
  localparam funct_t  functAdd = 6'b100000;
  localparam funct_t  functSub = 6'b100010;

  localparam aluOp_t aluAdd     = 3'd1;
  localparam aluOp_t aluSub     = 3'd2;
  localparam aluOp_t aluCompare = 3'd7;

  // Mux selects
  localparam muxSel2_t srcAPc          = 2'b00;
  localparam muxSel2_t srcARegA        = 2'b01;
  localparam muxSel2_t srcBRegB        = 2'b00;
  localparam muxSel2_t srcBFour        = 2'b01;
  localparam muxSel2_t srcBOffset      = 2'b10;
  localparam muxSel2_t srcBBranch      = 2'b11;  // Shifted offset
  localparam muxSel2_t regDstRt        = 2'b00;
  localparam muxSel2_t regDstRd        = 2'b01;
  localparam muxSel3_t memToRegAluOut  = 3'b000;
  localparam muxSel3_t pcSrcAluResult  = 3'b001;
  localparam muxSel3_t pcSrcAluOut     = 3'b010;

  // Fetch steps after the memory read, counted from MemReadCycles
  localparam int fetchWriteOffset  = 0;
  localparam int fetchAbOffset     = 1;
  localparam int fetchDecodeOffset = 2;

  localparam step_t aluExecSteps      = 4'd3;
  localparam step_t branchExecSteps   = 4'd4;
  localparam step_t branchCompareStep = 4'd1;

  function automatic logic isBranch(instrKind_t kind);
    return kind inside {kindBeq, kindBne, kindBle, kindBgt};
  endfunction

endpackage

`default_nettype wire

// ==== src/phaseSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer import ctrlPkg::*; #(
  parameter int MemReadCycles = 3
) (
  input  logic    clk,
  input  logic    reset,
  input  opcode_t opcode,
  input  funct_t  funct,
  output phase_t  phase,
  output logic    resetOut
);

  localparam step_t lastFetchStep = step_t'(MemReadCycles + fetchDecodeOffset);

  seqState_t  state;
  step_t      step;
  instrKind_t kind;
  instrKind_t decodedKind;
  step_t      lastExecStep;

  // Opcode and funct to instruction kind
  always_comb begin
    decodedKind = kindNone;
    case (opcode)
      opRType: begin
        if (funct == functAdd) begin
          decodedKind = kindAdd;
        end else if (funct == functSub) begin
          decodedKind = kindSub;
        end
      end
      opAddi:  decodedKind = kindAddi;
      opBeq:   decodedKind = kindBeq;
      opBne:   decodedKind = kindBne;
      opBle:   decodedKind = kindBle;
      opBgt:   decodedKind = kindBgt;
      default: decodedKind = kindNone;
    endcase
  end

  assign lastExecStep = isBranch(kind) ? branchExecSteps - 4'd1 : aluExecSteps - 4'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReset;
      step  <= '0;
      kind  <= kindNone;
    end else begin
      case (state)
        stReset: begin
          state <= stFetch;  // Leave on the first cycle without reset
          step  <= '0;
        end
        stFetch: begin
          if (step == lastFetchStep) begin
            // Decode step
            kind  <= decodedKind;
            step  <= '0;
            state <= (decodedKind == kindNone) ? stFetch : stExecute;
          end else begin
            step <= step + 4'd1;
          end
        end
        stExecute: begin
          if (step == lastExecStep) begin
            state <= stFetch;
            step  <= '0;
          end else begin
            step <= step + 4'd1;
          end
        end
        default: begin
          state <= stReset;
          step  <= '0;
        end
      endcase
    end
  end

  assign phase.state = state;
  assign phase.kind  = kind;
  assign phase.step  = step;

  assign resetOut = (state == stReset);

  // Last legal step for a state and kind
  function automatic step_t stepLimit(seqState_t st, instrKind_t k);
    step_t limit;
    case (st)
      stFetch:   limit = lastFetchStep;
      stExecute: limit = isBranch(k) ? branchExecSteps - 4'd1 : aluExecSteps - 4'd1;
      default:   limit = '0;
    endcase
    return limit;
  endfunction

  stepInRange: assert property (
    @(posedge clk) disable iff (reset)
    step <= stepLimit(state, kind)
  ) else $error("Step %0d out of range in state %s", step, state.name());

endmodule

`default_nettype wire

// ==== src/branchResolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchResolver import ctrlPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  phase_t    phase,
  input  aluFlags_t flags,
  output logic      branchTaken
);

  logic atCompare;

  // Branch condition per kind
  function automatic logic conditionMet(instrKind_t kind, aluFlags_t f);
    case (kind)
      kindBeq: return f.eq;
      kindBne: return !f.eq;
      kindBle: return !f.gt;
      kindBgt: return f.gt;
      default: return 1'b0;
    endcase
  endfunction

  assign atCompare = (phase.state == stExecute) && isBranch(phase.kind) &&
                     (phase.step == branchCompareStep);

  always_ff @(posedge clk) begin
    if (reset || phase.state == stFetch) begin
      branchTaken <= 1'b0;
    end else if (atCompare) begin
      branchTaken <= conditionMet(phase.kind, flags);  // Used in the next step
    end
  end

  // Kind only changes at decode, after the fetch has cleared the decision
  takenOnlyOnBranch: assert property (
    @(posedge clk) disable iff (reset)
    branchTaken |-> isBranch(phase.kind)
  );

endmodule

`default_nettype wire

// ==== src/controlEncoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlEncoder import ctrlPkg::*; #(
  parameter int MemReadCycles = 3
) (
  input  logic         clk,
  input  phase_t       phase,
  input  logic         branchTaken,
  output controlWord_t control
);

  localparam step_t writeStep = step_t'(MemReadCycles + fetchWriteOffset);
  localparam step_t abStep    = step_t'(MemReadCycles + fetchAbOffset);

  logic isImm;

  assign isImm = (phase.kind == kindAddi);

  always_comb begin
    control = '0;
    case (phase.state)
      stFetch: begin
        if (phase.step < writeStep) begin
          // Memory read while the ALU computes PC+4
          control.aluOutWrite = 1'b1;
          control.aluOp       = aluAdd;
          control.aluSrcA     = srcAPc;
          control.aluSrcB     = srcBFour;
          control.pcSource    = pcSrcAluResult;
        end else if (phase.step == writeStep) begin
          control.pcWrite  = 1'b1;
          control.irWrite  = 1'b1;
          control.pcSource = pcSrcAluOut;
        end else if (phase.step == abStep) begin
          control.abWrite = 1'b1;
        end
        // Decode step leaves everything low
      end

      stExecute: begin
        if (isBranch(phase.kind)) begin
          case (phase.step)
            4'd0: begin
              // Branch target into ALUOut
              control.aluOutWrite = 1'b1;
              control.aluOp       = aluAdd;
              control.aluSrcA     = srcAPc;
              control.aluSrcB     = srcBBranch;
            end
            4'd1, 4'd2: begin
              control.aluOp    = aluCompare;
              control.aluSrcA  = srcARegA;
              control.aluSrcB  = srcBRegB;
              control.pcSource = pcSrcAluOut;
              control.pcWrite  = (phase.step == 4'd2) && branchTaken;
            end
            default: ;  // Idle step
          endcase
        end else begin
          case (phase.step)
            4'd0: begin
              control.aluOutWrite = 1'b1;
              control.aluOp       = (phase.kind == kindSub) ? aluSub : aluAdd;
              control.aluSrcA     = srcARegA;
              control.aluSrcB     = isImm ? srcBOffset : srcBRegB;
            end
            4'd1: begin
              // Write back from ALUOut
              control.regWrite = 1'b1;
              control.memToReg = memToRegAluOut;
              control.regDst   = isImm ? regDstRt : regDstRd;
            end
            default: ;
          endcase
        end
      end

      default: ;  // Reset keeps the word at zero
    endcase
  end

  noIrWithRegWrite: assert property (
    @(posedge clk) !(control.irWrite && control.regWrite)
  ) else $error("irWrite and regWrite high together at step %0d", phase.step);

endmodule

`default_nettype wire

// ==== src/ctrlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlUnit import ctrlPkg::*; #(
  parameter int MemReadCycles = 3
) (
  input  logic      clk,
  input  logic      reset,
  input  opcode_t   opcode,
  input  offset_t   offset,
  input  aluFlags_t flags,
  output logic      resetOut,
  output logic      pcWrite,
  output logic      irWrite,
  output logic      regWrite,
  output logic      abWrite,
  output logic      aluOutWrite,
  output aluOp_t    aluOp,
  output muxSel2_t  aluSrcA,
  output muxSel2_t  aluSrcB,
  output muxSel2_t  regDst,
  output muxSel3_t  memToReg,
  output muxSel3_t  pcSource
);

  funct_t       funct;
  phase_t       phase;
  logic         branchTaken;
  controlWord_t control;

  assign funct = funct_t'(offset[5:0]);  // R-type function field

  phaseSequencer #(
    .MemReadCycles(MemReadCycles)
  ) sequencer (
    .clk     (clk),
    .reset   (reset),
    .opcode  (opcode),
    .funct   (funct),
    .phase   (phase),
    .resetOut(resetOut)
  );

  branchResolver resolver (
    .clk        (clk),
    .reset      (reset),
    .phase      (phase),
    .flags      (flags),
    .branchTaken(branchTaken)
  );

  controlEncoder #(
    .MemReadCycles(MemReadCycles)
  ) encoder (
    .clk        (clk),
    .phase      (phase),
    .branchTaken(branchTaken),
    .control    (control)
  );

  // Control word onto the datapath ports
  assign pcWrite     = control.pcWrite;
  assign irWrite     = control.irWrite;
  assign regWrite    = control.regWrite;
  assign abWrite     = control.abWrite;
  assign aluOutWrite = control.aluOutWrite;
  assign aluOp       = control.aluOp;
  assign aluSrcA     = control.aluSrcA;
  assign aluSrcB     = control.aluSrcB;
  assign regDst      = control.regDst;
  assign memToReg    = control.memToReg;
  assign pcSource    = control.pcSource;

endmodule

`default_nettype wire

// ==== verification/ctrlUnitTable.svh ====
`ifndef CTRL_UNIT_TABLE_SVH
`define CTRL_UNIT_TABLE_SVH

// Expected behaviour class of an entry
localparam logic [1:0] clsAluRd  = 2'd0;  // ADD, SUB
localparam logic [1:0] clsAluRt  = 2'd1;  // ADDI
localparam logic [1:0] clsBranch = 2'd2;
localparam logic [1:0] clsNone   = 2'd3;  // Unsupported kinds return to fetch

typedef struct packed {
  opcode_t    opcode;
  offset_t    offset;
  logic       randomFlags;
  aluFlags_t  flags;      // {eq, gt}
  logic [1:0] cls;
  aluOp_t     expAluOp;   // aluOp at the aluOutWrite after abWrite
} tableEntry_t;

localparam int tableSize = 27;

// Columns are opcode, offset, random flags, flags {eq, gt}, class and expected aluOp
localparam tableEntry_t testTable [tableSize] = '{
  '{opRType, 16'h1820, 1'b0, 2'b00, clsAluRd,  aluAdd},  // ADD
  '{opRType, 16'h2822, 1'b0, 2'b00, clsAluRd,  aluSub},  // SUB
  '{opAddi,  16'h0005, 1'b0, 2'b00, clsAluRt,  aluAdd},
  '{opAddi,  16'hfffc, 1'b0, 2'b00, clsAluRt,  aluAdd},
  '{opBeq,   16'h0010, 1'b0, 2'b10, clsBranch, aluAdd},
  '{opBeq,   16'h0010, 1'b0, 2'b00, clsBranch, aluAdd},
  '{opBne,   16'hfff0, 1'b0, 2'b10, clsBranch, aluAdd},
  '{opBne,   16'hfff0, 1'b0, 2'b01, clsBranch, aluAdd},
  '{opBle,   16'h0004, 1'b0, 2'b01, clsBranch, aluAdd},
  '{opBle,   16'h0004, 1'b0, 2'b00, clsBranch, aluAdd},
  '{opBgt,   16'h0008, 1'b0, 2'b01, clsBranch, aluAdd},
  '{opBgt,   16'h0008, 1'b0, 2'b10, clsBranch, aluAdd},
  '{6'h02,   16'h0000, 1'b0, 2'b00, clsNone,   aluAdd},  // Jump
  '{6'h23,   16'h0004, 1'b0, 2'b00, clsNone,   aluAdd},  // Load word
  '{opRType, 16'h1824, 1'b0, 2'b00, clsNone,   aluAdd},  // AND funct
  '{opBeq,   16'h0003, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBne,   16'h0003, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBle,   16'h0003, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBgt,   16'h0003, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBeq,   16'hff00, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBne,   16'hff00, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBle,   16'hff00, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBgt,   16'hff00, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBeq,   16'h0040, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBne,   16'h0040, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBle,   16'h0040, 1'b1, 2'b00, clsBranch, aluAdd},
  '{opBgt,   16'h0040, 1'b1, 2'b00, clsBranch, aluAdd}
};

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsrNext(logic [31:0] s);
  logic feedback;
  feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], feedback};
endfunction

`endif

// ==== verification/ctrlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlUnitTb import ctrlPkg::*; ();

  localparam int MemReadCycles = 3;
  localparam int timeoutMargin = 20;

  logic      clk;
  logic      reset;
  opcode_t   opcode;
  offset_t   offset;
  aluFlags_t flags;
  logic      resetOut;
  logic      pcWrite;
  logic      irWrite;
  logic      regWrite;
  logic      abWrite;
  logic      aluOutWrite;
  aluOp_t    aluOp;
  muxSel2_t  aluSrcA;
  muxSel2_t  aluSrcB;
  muxSel2_t  regDst;
  muxSel3_t  memToReg;
  muxSel3_t  pcSource;

  int errorCount = 0;
  int testsRun = 0;
  int testsPassed = 0;
  int cycleCount = 0;
  int timeoutLimit = 0;
  logic [31:0] lfsrState;

  `include "ctrlUnitTable.svh"

  ctrlUnit #(
    .MemReadCycles(MemReadCycles)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .opcode     (opcode),
    .offset     (offset),
    .flags      (flags),
    .resetOut   (resetOut),
    .pcWrite    (pcWrite),
    .irWrite    (irWrite),
    .regWrite   (regWrite),
    .abWrite    (abWrite),
    .aluOutWrite(aluOutWrite),
    .aluOp      (aluOp),
    .aluSrcA    (aluSrcA),
    .aluSrcB    (aluSrcB),
    .regDst     (regDst),
    .memToReg   (memToReg),
    .pcSource   (pcSource)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
      $display("Timeout: no progress after %0d cycles", cycleCount);
      $display("Test failures found");
      $finish;
    end
  end

  // Cycles from one irWrite to the next
  function automatic int periodLength(logic [1:0] cls);
    case (cls)
      clsBranch: return MemReadCycles + 7;
      clsNone:   return MemReadCycles + 3;
      default:   return MemReadCycles + 6;
    endcase
  endfunction

  function automatic int runLength();
    int total;
    total = 4 + MemReadCycles;  // Reset and the first fetch
    for (int i = 0; i < tableSize; i++) begin
      total += periodLength(testTable[i].cls);
    end
    return total + timeoutMargin;
  endfunction

  function automatic logic expectTaken(opcode_t op, aluFlags_t f);
    case (op)
      opBeq:   return f.eq;
      opBne:   return !f.eq;
      opBle:   return !f.gt;
      opBgt:   return f.gt;
      default: return 1'b0;
    endcase
  endfunction

  function automatic string instrName(tableEntry_t e);
    case (e.opcode)
      opRType: return (e.offset[5:0] == functAdd) ? "ADD" :
                      (e.offset[5:0] == functSub) ? "SUB" : "unsupported R-type";
      opAddi:  return "ADDI";
      opBeq:   return "BEQ";
      opBne:   return "BNE";
      opBle:   return "BLE";
      opBgt:   return "BGT";
      default: return "unsupported opcode";
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testsRun++;
    if (errorCount == errorsBefore) begin
      testsPassed++;
      $display("Test %0d %s: PASS", testsRun, name);
    end else begin
      $display("Test %0d %s: FAIL", testsRun, name);
    end
  endtask

  // Entered at the negedge where the fetch irWrite of this entry is high
  task automatic runEntry(input tableEntry_t e);
    aluFlags_t usedFlags;
    int        cycles;
    int        pcWrites;
    int        regWrites;
    int        errorsBefore;
    muxSel2_t  firstRegDst;
    aluOp_t    execAluOp;
    muxSel2_t  execSrcA;
    muxSel2_t  execSrcB;
    logic      abSeen;
    logic      aluSeen;
    logic      done;
    errorsBefore = errorCount;
    cycles = 1;
    pcWrites = int'(pcWrite);
    regWrites = int'(regWrite);
    firstRegDst = '0;
    execAluOp = '0;
    execSrcA = '0;
    execSrcB = '0;
    abSeen = 1'b0;
    aluSeen = 1'b0;
    done = 1'b0;
    if (pcWrite) begin
      checkValue("pcSource", pcSource, pcSrcAluOut);
    end
    if (e.randomFlags) begin
      lfsrState = lfsrNext(lfsrState);
      usedFlags.eq = lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
      usedFlags.gt = lfsrState[0];
    end else begin
      usedFlags = e.flags;
    end
    @(posedge clk);
    opcode <= e.opcode;  // Ready before the decode step
    offset <= e.offset;
    flags  <= usedFlags;
    while (!done) begin
      @(negedge clk);
      if (irWrite) begin
        done = 1'b1;
      end else begin
        cycles++;
        pcWrites = pcWrites + int'(pcWrite);
        if (pcWrite) begin
          checkValue("pcSource", pcSource, pcSrcAluOut);  // New PC always from ALUOut
        end
        if (regWrite) begin
          if (regWrites == 0) firstRegDst = regDst;
          checkValue("memToReg", memToReg, memToRegAluOut);
          regWrites++;
        end
        if (abWrite) begin
          abSeen = 1'b1;
        end else if (abSeen && aluOutWrite && !aluSeen) begin
          execAluOp = aluOp;  // First execute ALU step
          execSrcA = aluSrcA;
          execSrcB = aluSrcB;
          aluSeen = 1'b1;
        end
      end
    end
    checkValue("irWrite period", cycles, periodLength(e.cls));
    case (e.cls)
      clsAluRd, clsAluRt: begin
        checkValue("regWrite count", regWrites, 1);
        checkValue("regDst", firstRegDst, (e.cls == clsAluRt) ? regDstRt : regDstRd);
        checkValue("pcWrite count", pcWrites, 1);
        checkValue("aluOp", execAluOp, e.expAluOp);
        checkValue("aluSrcA", execSrcA, srcARegA);
        checkValue("aluSrcB", execSrcB, (e.cls == clsAluRt) ? srcBOffset : srcBRegB);
      end
      clsBranch: begin
        checkValue("regWrite count", regWrites, 0);
        checkValue("pcWrite count", pcWrites, 1 + int'(expectTaken(e.opcode, usedFlags)));
        checkValue("aluOp", execAluOp, e.expAluOp);
        checkValue("aluSrcA", execSrcA, srcAPc);
        checkValue("aluSrcB", execSrcB, srcBBranch);
      end
      default: begin
        checkValue("regWrite count", regWrites, 0);
        checkValue("pcWrite count", pcWrites, 1);
      end
    endcase
    reportTest($sformatf("%s flags eq=%0b gt=%0b", instrName(e), usedFlags.eq, usedFlags.gt),
               errorsBefore);
  endtask

  initial begin
    int errorsBefore;
    int waitCycles;
    reset = 1'b1;
    opcode = '0;
    offset = '0;
    flags = '0;
    lfsrState = 32'hd284;
    timeoutLimit = runLength();

    // Reset held for three rising edges
    errorsBefore = errorCount;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) reset <= 1'b0;
      @(negedge clk);
      checkValue("resetOut", resetOut, 1);
      checkValue("control outputs", {pcWrite, irWrite, regWrite, abWrite, aluOutWrite, aluOp,
                 aluSrcA, aluSrcB, regDst, memToReg, pcSource}, 0);
    end
    @(negedge clk);
    checkValue("resetOut", resetOut, 0);
    waitCycles = 0;
    while (irWrite !== 1'b1) begin
      @(negedge clk);
      waitCycles++;
    end
    checkValue("cycles from resetOut fall to irWrite", waitCycles, MemReadCycles);
    reportTest("Reset", errorsBefore);

    for (int i = 0; i < tableSize; i++) begin
      runEntry(testTable[i]);
    end

    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             testsRun, testsPassed, testsRun - testsPassed, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/ctrlPkg.sv
src/phaseSequencer.sv
src/branchResolver.sv
src/controlEncoder.sv
src/ctrlUnit.sv
+incdir+verification
verification/ctrlUnitTb.sv
